//--- hdl/mips_pkg.sv
package mips_pkg;

    // ------------------------------
    // primary opcodes
    // ------------------------------
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;

    // function codes under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // boot rom base, first fetch address
    localparam logic [31:0] reset_pc = 32'hbfc0_0000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_lui,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // ------------------------------
    // instruction word, two views
    // ------------------------------
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } inst_i_t;

    // jump index is {rs, rt, imm} of the i view
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    // ------------------------------
    // stage payloads
    // ------------------------------
    typedef struct packed {
        logic [31:0] pc;
        alu_op_t     alu_op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  waddr;
        logic        reg_write;
        // result is pc+8
        logic        link;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  waddr;
        logic        reg_write;
        logic [31:0] result;
    } wb_t;

    // one per stage, EX/MEM/WB back to decode
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  waddr;
        logic [31:0] data;
        logic        ready;
    } fwd_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu import mips_pkg::*; (
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    // shift amount in a, shifted value in b
    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'd0, a < b};
            // upper half from imm
            alu_lui:  result = {b[15:0], 16'd0};
            alu_sll:  result = b << a[4:0];
            alu_srl:  result = b >> a[4:0];
            alu_sra:  result = $unsigned($signed(b) >>> a[4:0]);
            default:  result = 32'd0;
        endcase
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // write at the clock edge
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, r0 reads zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    // decode drops r0 destinations before they get here
    a_no_r0_write: assert property (@(posedge clk) wen |-> waddr != 5'd0);

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import mips_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // instruction bus
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    input  logic        inst_addr_ok,
    input  logic        inst_data_ok,
    // from decode
    input  logic        stall,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    // IF/ID register
    output logic        if_valid,
    output inst_t       if_inst,
    output logic [31:0] if_pc
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_full
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t state_nxt;
    logic [31:0]  pc;
    logic [31:0]  pc_nxt;
    logic [31:0]  hold_word;
    logic         redir_valid;
    logic [31:0]  redir_pc;
    logic         word_ready;
    logic         ifid_free;
    logic         load;

    // word on the bus this cycle, or parked in hold_word
    assign word_ready = (state == st_data && inst_data_ok) || state == st_full;
    // IF/ID drains unless decode holds it
    assign ifid_free  = !if_valid || !stall;
    assign load       = word_ready && ifid_free;

    // one request at a time, address is the fetch pc
    assign inst_req  = (state == st_addr);
    assign inst_addr = pc;

    // ------------------------------
    // bus request FSM
    // ------------------------------
    always_comb begin
        case (state)
            st_idle: state_nxt = st_addr;
            st_addr: state_nxt = inst_addr_ok ? st_data : st_addr;
            // word arrived but IF/ID busy, park it
            st_data: state_nxt = !inst_data_ok ? st_data : (load ? st_addr : st_full);
            st_full: state_nxt = load ? st_addr : st_full;
            default: state_nxt = st_idle;
        endcase
    end

    // delay slot is loaded while or after its branch leaves ID
    assign pc_nxt = branch_taken ? branch_target :
                    redir_valid  ? redir_pc      : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= st_idle;
            pc          <= reset_pc;
            redir_valid <= 1'b0;
            if_valid    <= 1'b0;
        end else begin
            state <= state_nxt;
            // pc moves only when its word enters IF/ID
            if (load) begin
                pc <= pc_nxt;
            end
            // taken branch waits here for its delay slot
            if (load) begin
                redir_valid <= 1'b0;
            end else if (branch_taken) begin
                redir_valid <= 1'b1;
            end
            if (load) begin
                if_valid <= 1'b1;
            end else if (!stall) begin
                if_valid <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (branch_taken && !load) begin
            redir_pc <= branch_target;
        end
        if (state == st_data && inst_data_ok) begin
            hold_word <= inst_rdata;
        end
        if (load) begin
            if_inst <= (state == st_full) ? hold_word : inst_rdata;
            if_pc   <= pc;
        end
    end

    // address held until accepted
    a_addr_stable: assert property (@(posedge clk) disable iff (!resetn)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr));

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        if_valid,
    input  inst_t       if_inst,
    input  logic [31:0] if_pc,
    // register file
    output logic [4:0]  raddr1,
    output logic [4:0]  raddr2,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    // forwarding
    input  fwd_t        fwd_ex,
    input  fwd_t        fwd_mem,
    input  fwd_t        fwd_wb,
    // to fetch
    output logic        stall,
    output logic        branch_taken,
    output logic [31:0] branch_target,
    // ID/EX register
    output logic        id_valid,
    output id_ex_t      id_ex
);

    logic [5:0]  op;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] pc_ds;
    alu_op_t     alu_op;
    logic        r_write;
    logic        use_imm;
    logic        use_zext;
    logic        use_sa;
    logic        link;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic        is_jr;
    logic        ex_busy_rs;
    logic        ex_busy_rt;
    logic [4:0]  waddr;

    // youngest matching stage wins, r0 never matches
    function automatic logic [31:0] fwd_pick(input logic [4:0] addr, input logic [31:0] rf,
                                             input fwd_t ex, input fwd_t mem, input fwd_t wb);
        return (ex.reg_write && ex.waddr == addr)   ? ex.data  :
               (mem.reg_write && mem.waddr == addr) ? mem.data :
               (wb.reg_write && wb.waddr == addr)   ? wb.data  : rf;
    endfunction

    // ------------------------------
    // field extraction
    // ------------------------------
    assign op       = if_inst.r.op;
    assign funct    = if_inst.r.funct;
    assign rs       = if_inst.i.rs;
    assign rt       = if_inst.i.rt;
    assign imm_sext = {{16{if_inst.i.imm[15]}}, if_inst.i.imm};
    assign imm_zext = {16'd0, if_inst.i.imm};
    assign raddr1   = rs;
    assign raddr2   = rt;

    assign use_imm  = (op != op_special);
    assign use_zext = op inside {op_andi, op_ori, op_xori, op_lui};
    assign use_sa   = (op == op_special) && (funct inside {fn_sll, fn_srl, fn_sra});
    assign link     = (op == op_jal);
    assign is_beq   = (op == op_beq);
    assign is_bne   = (op == op_bne);
    assign is_j     = (op == op_j) || (op == op_jal);
    assign is_jr    = (op == op_special) && (funct == fn_jr);

    // jal to r31, i-format to rt, else rd
    assign waddr = link ? 5'd31 : (use_imm ? rt : if_inst.r.rd);

    always_comb begin
        alu_op  = alu_add;
        r_write = 1'b1;
        case (op)
            op_special: begin
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    // jr and unknown functs
                    default: r_write = 1'b0;
                endcase
            end
            // jal result comes from the link path
            op_addiu, op_jal: alu_op = alu_add;
            op_slti: alu_op = alu_slt;
            op_andi: alu_op = alu_and;
            op_ori:  alu_op = alu_or;
            op_xori: alu_op = alu_xor;
            op_lui:  alu_op = alu_lui;
            default: r_write = 1'b0;
        endcase
    end

    // ------------------------------
    // operands and branch
    // ------------------------------
    assign fa = fwd_pick(rs, rdata1, fwd_ex, fwd_mem, fwd_wb);
    assign fb = fwd_pick(rt, rdata2, fwd_ex, fwd_mem, fwd_wb);

    // branch compare cannot use an unlatched EX result
    assign ex_busy_rs = fwd_ex.reg_write && fwd_ex.waddr == rs && !fwd_ex.ready;
    assign ex_busy_rt = fwd_ex.reg_write && fwd_ex.waddr == rt && !fwd_ex.ready;
    assign stall = if_valid && (((is_beq || is_bne || is_jr) && ex_busy_rs) ||
                                ((is_beq || is_bne) && ex_busy_rt));

    assign pc_ds = if_pc + 32'd4;
    assign branch_taken = if_valid && !stall &&
                          ((is_beq && fa == fb) || (is_bne && fa != fb) || is_j || is_jr);
    // targets relative to the delay slot
    assign branch_target = is_jr ? fa :
                           is_j  ? {pc_ds[31:28], if_inst.i.rs, if_inst.i.rt, if_inst.i.imm, 2'b00} :
                                   pc_ds + {imm_sext[29:0], 2'b00};

    // ------------------------------
    // ID/EX register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else begin
            // stall sends a bubble
            id_valid <= if_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        id_ex <= '{pc:        if_pc,
                   alu_op:    alu_op,
                   a:         use_sa ? {27'd0, if_inst.r.shamt} : fa,
                   b:         use_imm ? (use_zext ? imm_zext : imm_sext) : fb,
                   waddr:     waddr,
                   reg_write: r_write && waddr != 5'd0,
                   link:      link};
    end

    // producer is in MEM next cycle, so one stall cycle at most
    a_stall_once: assert property (@(posedge clk) disable iff (!resetn)
        stall |-> if_valid ##1 !stall);

endmodule

//--- hdl/back_end.sv
`timescale 1ns/10ps

module back_end import mips_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        id_valid,
    input  id_ex_t      id_ex,
    // forwarding to decode
    output fwd_t        fwd_ex,
    output fwd_t        fwd_mem,
    output fwd_t        fwd_wb,
    // register file write
    output logic        rf_wen,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    // debug writeback
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic [31:0] alu_result;
    logic [31:0] ex_result;
    wb_t         ex_mem;
    wb_t         mem_wb;
    logic        ex_mem_valid;
    logic        mem_wb_valid;

    // ------------------------------
    // EX
    // ------------------------------
    alu u_alu (
        .op     (id_ex.alu_op),
        .a      (id_ex.a),
        .b      (id_ex.b),
        .result (alu_result)
    );

    // link writes the address after the delay slot
    assign ex_result = id_ex.link ? id_ex.pc + 32'd8 : alu_result;

    // ------------------------------
    // EX/MEM and MEM/WB
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            ex_mem_valid <= id_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    // no loads, MEM only carries the result
    always_ff @(posedge clk) begin
        ex_mem <= '{pc:        id_ex.pc,
                    waddr:     id_ex.waddr,
                    reg_write: id_ex.reg_write,
                    result:    ex_result};
        mem_wb <= ex_mem;
    end

    // EX result is still combinational
    assign fwd_ex = '{reg_write: id_valid && id_ex.reg_write,
                      waddr:     id_ex.waddr,
                      data:      ex_result,
                      ready:     1'b0};

    assign fwd_mem = '{reg_write: ex_mem_valid && ex_mem.reg_write,
                       waddr:     ex_mem.waddr,
                       data:      ex_mem.result,
                       ready:     1'b1};

    assign fwd_wb = '{reg_write: mem_wb_valid && mem_wb.reg_write,
                      waddr:     mem_wb.waddr,
                      data:      mem_wb.result,
                      ready:     1'b1};

    // ------------------------------
    // writeback and debug port
    // ------------------------------
    assign rf_wen   = mem_wb_valid && mem_wb.reg_write;
    assign rf_waddr = mem_wb.waddr;
    assign rf_wdata = mem_wb.result;

    // all four byte enables for a word write
    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_wen   = {4{rf_wen}};
    assign debug_wb_rf_wnum  = mem_wb.waddr;
    assign debug_wb_rf_wdata = mem_wb.result;

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // instruction bus
    output logic        inst_req,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    input  logic        inst_addr_ok,
    input  logic        inst_data_ok,
    // debug writeback
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    // IF/ID
    logic        if_valid;
    inst_t       if_inst;
    logic [31:0] if_pc;
    // ID back to fetch
    logic        stall;
    logic        branch_taken;
    logic [31:0] branch_target;
    // ID/EX
    logic        id_valid;
    id_ex_t      id_ex;
    // forwarding
    fwd_t        fwd_ex;
    fwd_t        fwd_mem;
    fwd_t        fwd_wb;
    // register file
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        rf_wen;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    fetch_unit u_fetch (
        .clk           (clk),
        .resetn        (resetn),
        .inst_req      (inst_req),
        .inst_addr     (inst_addr),
        .inst_rdata    (inst_rdata),
        .inst_addr_ok  (inst_addr_ok),
        .inst_data_ok  (inst_data_ok),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .if_valid      (if_valid),
        .if_inst       (if_inst),
        .if_pc         (if_pc)
    );

    decode_stage u_decode (
        .clk           (clk),
        .resetn        (resetn),
        .if_valid      (if_valid),
        .if_inst       (if_inst),
        .if_pc         (if_pc),
        .raddr1        (raddr1),
        .raddr2        (raddr2),
        .rdata1        (rdata1),
        .rdata2        (rdata2),
        .fwd_ex        (fwd_ex),
        .fwd_mem       (fwd_mem),
        .fwd_wb        (fwd_wb),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_valid      (id_valid),
        .id_ex         (id_ex)
    );

    reg_file u_rf (
        .clk    (clk),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    back_end u_back (
        .clk               (clk),
        .resetn            (resetn),
        .id_valid          (id_valid),
        .id_ex             (id_ex),
        .fwd_ex            (fwd_ex),
        .fwd_mem           (fwd_mem),
        .fwd_wb            (fwd_wb),
        .rf_wen            (rf_wen),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ------------------------------
// program memory and model state
// ------------------------------
logic [31:0] prog [max_words];
int          prog_words;
logic [31:0] end_pc;
logic [31:0] m_regs [32];
logic [31:0] m_pc;
logic [31:0] m_npc;

function automatic int urand(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

function automatic logic [31:0] addr_of(input int idx);
    return reset_pc + 32'(idx * 4);
endfunction

function automatic bit in_program(input logic [31:0] addr);
    return (addr - reset_pc) < 32'(prog_words * 4);
endfunction

// out of range reads as a nop
function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (!in_program(addr)) begin
        return 32'd0;
    end
    return prog[(addr - reset_pc) >> 2];
endfunction

function automatic void emit(input logic [31:0] w);
    prog[prog_words] = w;
    prog_words++;
endfunction

// r1..r8, small set so dependencies are frequent
function automatic logic [4:0] rand_reg();
    return 5'(1 + urand(8));
endfunction

function automatic logic [31:0] rand_alu();
    logic [5:0] r_fn [8] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
    logic [5:0] s_fn [3] = '{fn_sll, fn_srl, fn_sra};
    logic [5:0] i_op [6] = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
    logic [4:0] rd;
    int         k;
    // r0 as destination now and then
    rd = 5'(urand(9));
    k  = urand(17);
    if (k < 8) begin
        return {op_special, rand_reg(), rand_reg(), rd, 5'd0, r_fn[k]};
    end else if (k < 11) begin
        return {op_special, 5'd0, rand_reg(), rd, 5'(urand(32)), s_fn[k - 8]};
    end
    return {i_op[k - 11], rand_reg(), rd, 16'(urand(65536))};
endfunction

// ------------------------------
// program builder
// ------------------------------
function automatic void build_program();
    int          skip;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] tgt;
    prog_words = 0;
    for (int r = 1; r <= 8; r++) begin
        emit({op_addiu, 5'd0, 5'(r), 16'(urand(65536))});
    end
    // all control flow goes forward, so the program ends
    repeat (14) begin
        repeat (2 + urand(4)) emit(rand_alu());
        skip = 1 + urand(3);
        ra   = rand_reg();
        rb   = (urand(3) == 0) ? ra : rand_reg();
        case (urand(5))
            0: emit({(urand(2) == 0) ? op_beq : op_bne, ra, rb, 16'(skip + 1)});
            1: begin
                tgt = addr_of(prog_words + 2 + skip);
                emit({op_j, tgt[27:2]});
            end
            2: begin
                tgt = addr_of(prog_words + 2 + skip);
                emit({op_jal, tgt[27:2]});
            end
            3: begin
                // jr right after its source is written
                tgt = addr_of(prog_words + 4 + skip);
                emit({op_lui, 5'd0, 5'd9, tgt[31:16]});
                emit({op_ori, 5'd9, 5'd9, tgt[15:0]});
                emit({op_special, 5'd9, 15'd0, fn_jr});
            end
            default: begin
                // compare against a value written one instruction earlier
                emit({op_addiu, rb, ra, 16'(urand(3))});
                emit({(urand(2) == 0) ? op_beq : op_bne, ra, rb, 16'(skip + 1)});
            end
        endcase
        // delay slot, then the skipped words
        emit(rand_alu());
        repeat (skip) emit(rand_alu());
    end
    // final loop on itself with a nop in its delay slot
    end_pc = addr_of(prog_words);
    emit({op_j, end_pc[27:2]});
    emit(32'd0);
endfunction

// ------------------------------
// instruction-level model
// ------------------------------
function automatic void reset_model();
    foreach (m_regs[r]) begin
        m_regs[r] = 32'd0;
    end
    m_pc  = reset_pc;
    m_npc = reset_pc + 32'd4;
endfunction

function automatic bit model_step(output logic [31:0] pc, output logic [4:0] num,
                                  output logic [31:0] val);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] nxt;
    logic [4:0]  dst;
    bit          wr;
    w   = word_at(m_pc);
    a   = m_regs[w[25:21]];
    b   = m_regs[w[20:16]];
    sx  = {{16{w[15]}}, w[15:0]};
    nxt = m_npc + 32'd4;
    dst = w[20:16];
    val = 32'd0;
    wr  = 1'b1;
    case (w[31:26])
        op_special: begin
            dst = w[15:11];
            case (w[5:0])
                fn_addu: val = a + b;
                fn_subu: val = a - b;
                fn_and:  val = a & b;
                fn_or:   val = a | b;
                fn_xor:  val = a ^ b;
                fn_nor:  val = ~(a | b);
                fn_slt:  val = {31'd0, $signed(a) < $signed(b)};
                fn_sltu: val = {31'd0, a < b};
                fn_sll:  val = b << w[10:6];
                fn_srl:  val = b >> w[10:6];
                fn_sra:  val = $unsigned($signed(b) >>> w[10:6]);
                fn_jr: begin
                    wr  = 1'b0;
                    nxt = a;
                end
                default: wr = 1'b0;
            endcase
        end
        op_addiu: val = a + sx;
        op_slti:  val = {31'd0, $signed(a) < $signed(sx)};
        op_andi:  val = a & {16'd0, w[15:0]};
        op_ori:   val = a | {16'd0, w[15:0]};
        op_xori:  val = a ^ {16'd0, w[15:0]};
        op_lui:   val = {w[15:0], 16'd0};
        op_beq: begin
            wr = 1'b0;
            if (a == b) nxt = m_npc + {sx[29:0], 2'b00};
        end
        op_bne: begin
            wr = 1'b0;
            if (a != b) nxt = m_npc + {sx[29:0], 2'b00};
        end
        op_j: begin
            wr  = 1'b0;
            nxt = {m_npc[31:28], w[25:0], 2'b00};
        end
        op_jal: begin
            dst = 5'd31;
            val = m_pc + 32'd8;
            nxt = {m_npc[31:28], w[25:0], 2'b00};
        end
        default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) m_regs[dst] = val;
    pc    = m_pc;
    num   = dst;
    m_pc  = m_npc;
    m_npc = nxt;
    return wr && dst != 5'd0;
endfunction

// next register write in program order, 0 once the end loop is reached
function automatic bit next_expected(output logic [31:0] pc, output logic [4:0] num,
                                     output logic [31:0] val);
    for (int n = 0; n < 4 * max_words; n++) begin
        if (m_pc == end_pc) return 1'b0;
        if (model_step(pc, num, val)) return 1'b1;
    end
    return 1'b0;
endfunction

`endif

//--- tb/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import mips_pkg::*; ();

    localparam int max_words = 256;

    logic        clk;
    logic        resetn;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    integer seed;
    int     err_mismatch;
    int     err_other;
    int     wb_seen;
    int     total_wb;

    `include "tb_ref_model.svh"

    cpu_core DUT (
        .clk               (clk),
        .resetn            (resetn),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .inst_addr_ok      (inst_addr_ok),
        .inst_data_ok      (inst_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // instruction memory, random latency
    // ------------------------------
    initial begin
        bit          busy;
        int          cnt;
        logic [31:0] req_addr;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata   = 32'd0;
        busy         = 1'b0;
        cnt          = 0;
        req_addr     = 32'd0;
        forever begin
            @(posedge clk);
            inst_data_ok <= 1'b0;
            if (!resetn) begin
                inst_addr_ok <= 1'b0;
                busy = 1'b0;
                cnt  = urand(4);
            end else if (!busy) begin
                // address phase, addr_ok may lead the request
                if (inst_req && inst_addr_ok) begin
                    inst_addr_ok <= 1'b0;
                    req_addr = inst_addr;
                    cnt      = urand(4);
                    busy     = 1'b1;
                end else begin
                    // count only cycles where the request waits
                    if (inst_req && cnt != 0) begin
                        cnt--;
                    end
                    if (cnt == 0) begin
                        inst_addr_ok <= 1'b1;
                    end
                end
            end
            // data phase, word comes after the accepting cycle
            if (busy) begin
                if (cnt == 0) begin
                    if (!in_program(req_addr)) begin
                        err_other++;
                        $display("%0t: fetch from %h lies outside the program", $time,
                                 req_addr);
                    end
                    inst_data_ok <= 1'b1;
                    inst_rdata   <= word_at(req_addr);
                    busy = 1'b0;
                    // delay for the next address
                    cnt  = urand(4);
                    if (cnt == 0) begin
                        inst_addr_ok <= 1'b1;
                    end
                end else begin
                    cnt--;
                end
            end
        end
    end

    // first fetch goes to the reset vector
    initial begin
        wait (resetn === 1'b1);
        do @(posedge clk); while (!inst_req);
        if (inst_addr !== reset_pc) begin
            err_mismatch++;
            $display("MISMATCH at %0t: inst_addr expected %h actual %h", $time, reset_pc,
                     inst_addr);
        end
    end

    // ------------------------------
    // writeback checker
    // ------------------------------
    always @(posedge clk) begin
        logic [31:0] e_pc;
        logic [4:0]  e_num;
        logic [31:0] e_val;
        if (resetn && debug_wb_rf_wen != 4'h0) begin
            if (!next_expected(e_pc, e_num, e_val)) begin
                err_other++;
                $display("%0t: register write to r%0d from pc %h, but the program has none left",
                         $time, debug_wb_rf_wnum, debug_wb_pc);
            end else begin
                wb_seen++;
                if (debug_wb_rf_wen !== 4'hf) begin
                    err_mismatch++;
                    $display("MISMATCH at %0t: debug_wb_rf_wen expected f actual %h", $time,
                             debug_wb_rf_wen);
                end
                if (debug_wb_pc !== e_pc) begin
                    err_mismatch++;
                    $display("MISMATCH at %0t: debug_wb_pc expected %h actual %h", $time, e_pc,
                             debug_wb_pc);
                end
                if (debug_wb_rf_wnum !== e_num) begin
                    err_mismatch++;
                    $display("MISMATCH at %0t: debug_wb_rf_wnum expected %0d actual %0d", $time,
                             e_num, debug_wb_rf_wnum);
                end
                if (debug_wb_rf_wdata !== e_val) begin
                    err_mismatch++;
                    $display("MISMATCH at %0t: debug_wb_rf_wdata expected %h actual %h", $time,
                             e_val, debug_wb_rf_wdata);
                end
            end
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        logic [31:0] d_pc;
        logic [4:0]  d_num;
        logic [31:0] d_val;
        seed         = 32'hbc61_9992;
        err_mismatch = 0;
        err_other    = 0;
        wb_seen      = 0;
        total_wb     = 0;
        resetn       = 1'b0;
        build_program();
        // dry run of the model to count the writes
        reset_model();
        while (next_expected(d_pc, d_num, d_val)) total_wb++;
        reset_model();
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        while (wb_seen < total_wb) @(posedge clk);
        // catch any extra writes after the last one
        repeat (40) @(posedge clk);
        $display("errors: %0d mismatches, %0d other, %0d of %0d writes seen", err_mismatch,
                 err_other, wb_seen, total_wb);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog, 400 cycles per program word
    initial begin
        #1;
        repeat (16 + 400 * prog_words) @(posedge clk);
        $display("run timed out with %0d of %0d writes seen", wb_seen, total_wb);
        $display("errors: %0d mismatches, %0d other", err_mismatch, err_other + 1);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+tb
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/back_end.sv
hdl/cpu_core.sv
tb/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu \
    -f build.f \
    --Mdir obj_dir \
    -o tb_cpu_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    exit 0
fi
exit 1
